// ==== src/elevator_params.svh ====
//////////////////////////////////////////////////////////////////////
// Sizes for the floor request controller. ELEV_QUEUE_DEPTH must stay
// at least twice the floor count, and ELEV_QUEUE_PTR_W must address it
//////////////////////////////////////////////////////////////////////

`ifndef ELEVATOR_PARAMS_SVH
`define ELEVATOR_PARAMS_SVH

// Floors served with floor 1 at index 0
`define ELEV_FLOOR_COUNT 11

// One panel and one call entry per floor fit with room to spare
`define ELEV_QUEUE_DEPTH 32

// Read and write pointer width
`define ELEV_QUEUE_PTR_W 5

`endif

// ==== src/elevator_pkg.sv ====
//////////////////////////////////////////////////////////////////////
// Shared types of the floor request controller. Floor numbers are
// zero based: floor 1 is 0 and floor 11 is 10
//////////////////////////////////////////////////////////////////////

`default_nettype none

package elevator_pkg;

    typedef logic [3:0] floor_t;

    typedef enum logic {
        DIR_DOWN = 1'b0,
        DIR_UP   = 1'b1
    } direction_t;

    // Single-cycle strobe carrying a floor
    typedef struct packed {
        logic   valid;
        floor_t floor;
    } floor_request_t;

    typedef enum logic [1:0] {
        DISPATCH_IDLE   = 2'd0,
        DISPATCH_TRAVEL = 2'd1
    } dispatch_state_t;

    // Car status as seen by the controller
    typedef struct packed {
        logic   power_on;
        logic   emergency;
        logic   moving;
        floor_t current_floor;
    } elevator_status_t;

endpackage

`default_nettype wire

// ==== src/request_latch.sv ====
//////////////////////////////////////////////////////////////////////
// Button latch. One request per cycle, panel before call, lowest floor
// first. Losing buttons are picked up again in later cycles
//////////////////////////////////////////////////////////////////////

`default_nettype none

`include "elevator_params.svh"

module request_latch (
    input  wire                                clock,
    input  wire                                reset_n,
    input  elevator_pkg::elevator_status_t     status,
    input  wire  [`ELEV_FLOOR_COUNT-1:0]       floor_call_buttons,
    input  wire  [`ELEV_FLOOR_COUNT-1:0]       panel_buttons,
    input  elevator_pkg::floor_request_t       served,
    output elevator_pkg::floor_request_t       new_request,
    output logic [`ELEV_FLOOR_COUNT-1:0]       call_button_lights,
    output logic [`ELEV_FLOOR_COUNT-1:0]       panel_button_lights
);

    localparam int N = `ELEV_FLOOR_COUNT;

    logic                         enabled;
    logic [N-1:0]                 here_mask;
    logic [N-1:0]                 clear_mask;
    logic [N-1:0]                 panel_qual;
    logic [N-1:0]                 call_qual;
    logic [N-1:0]                 panel_set;
    logic [N-1:0]                 call_set;
    elevator_pkg::floor_request_t panel_pick;
    elevator_pkg::floor_request_t call_pick;

    // One-hot lamp mask of a floor
    function automatic logic [N-1:0] floor_mask(input elevator_pkg::floor_t f);
        return {{(N-1){1'b0}}, 1'b1} << f;
    endfunction

    // Lowest set bit wins, so scan from the top down
    function automatic elevator_pkg::floor_request_t lowest_set(input logic [N-1:0] vec);
        elevator_pkg::floor_request_t pick;
        pick = '0;
        for (int i = N - 1; i >= 0; i--) begin
            if (vec[i]) begin
                pick.valid = 1'b1;
                pick.floor = elevator_pkg::floor_t'(i);
            end
        end
        return pick;
    endfunction

    assign enabled    = status.power_on && !status.emergency;
    assign here_mask  = floor_mask(status.current_floor);
    assign clear_mask = served.valid ? floor_mask(served.floor) : '0;

    // Pressed, lamp still dark, and not the floor the car is at
    assign panel_qual = enabled ? (panel_buttons & ~panel_button_lights & ~here_mask) : '0;
    assign call_qual  = enabled ? (floor_call_buttons & ~call_button_lights & ~here_mask) : '0;

    assign panel_pick = lowest_set(panel_qual);
    assign call_pick  = lowest_set(call_qual);

    // A call winner waits whenever the panel group has one
    assign panel_set = panel_pick.valid ? floor_mask(panel_pick.floor) : '0;
    assign call_set  = (!panel_pick.valid && call_pick.valid) ? floor_mask(call_pick.floor) : '0;

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            panel_button_lights <= '0;
            call_button_lights  <= '0;
            new_request         <= '0;
        end else begin
            // Service clears after the set so a served floor ends dark
            panel_button_lights <= (panel_button_lights | panel_set) & ~clear_mask;
            call_button_lights  <= (call_button_lights | call_set) & ~clear_mask;
            new_request         <= panel_pick.valid ? panel_pick : call_pick;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Checks

    // The issued floor differs from where the car stood when it was picked
    a_no_request_here : assert property (
        @(posedge clock) disable iff (!reset_n)
        new_request.valid |-> new_request.floor != $past(status.current_floor)
    );

endmodule

`default_nettype wire

// ==== src/floor_queue.sv ====
//////////////////////////////////////////////////////////////////////
// Request FIFO in arrival order. No back-pressure, so the depth has to
// cover every request that can be outstanding at once
//////////////////////////////////////////////////////////////////////

`default_nettype none

`include "elevator_params.svh"

module floor_queue (
    input  wire                          clock,
    input  wire                          reset_n,
    input  elevator_pkg::floor_request_t push,
    input  elevator_pkg::floor_request_t pop,
    output elevator_pkg::floor_request_t head
);

    localparam int DEPTH = `ELEV_QUEUE_DEPTH;
    localparam int PTR_W = `ELEV_QUEUE_PTR_W;

    elevator_pkg::floor_t mem [DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   count;

    // Pointer step that wraps after the last entry
    function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Storage

    always_ff @(posedge clock) begin
        if (push.valid) begin
            mem[wr_ptr] <= push.floor;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Pointers and occupancy

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push.valid) begin
                wr_ptr <= ptr_next(wr_ptr);
            end
            if (pop.valid) begin
                rd_ptr <= ptr_next(rd_ptr);
            end
            // Push and pop together leave the count alone
            case ({push.valid, pop.valid})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Head is visible from the edge that wrote it
    assign head.valid = (count != '0);
    assign head.floor = mem[rd_ptr];

    //////////////////////////////////////////////////////////////////////
    // Checks

    a_no_overflow : assert property (
        @(posedge clock) disable iff (!reset_n)
        push.valid |-> count != (PTR_W+1)'(DEPTH)
    );

    // Dispatch only retires the entry it was shown
    a_pop_matches_head : assert property (
        @(posedge clock) disable iff (!reset_n)
        pop.valid |-> head.valid && pop.floor == head.floor
    );

endmodule

`default_nettype wire

// ==== src/dispatch_control.sv ====
//////////////////////////////////////////////////////////////////////
// Dispatch FSM. Sends the queue head to the drive logic, one trip at a
// time, and grants door permission while the car stands still
//////////////////////////////////////////////////////////////////////

`default_nettype none

module dispatch_control (
    input  wire                            clock,
    input  wire                            reset_n,
    input  elevator_pkg::elevator_status_t status,
    input  elevator_pkg::floor_request_t   head,
    input  wire                            door_open_btn,
    input  wire                            door_close_btn,
    output elevator_pkg::floor_request_t   served,
    output elevator_pkg::floor_t           target_floor,
    output elevator_pkg::direction_t       direction,
    output logic                           activate_elevator,
    output logic                           door_open_allowed,
    output logic                           door_close_allowed
);

    elevator_pkg::dispatch_state_t state;

    logic enabled;
    logic stopped;
    logic arrived;

    assign enabled = status.power_on && !status.emergency;
    assign stopped = enabled && !status.moving;
    assign arrived = !status.moving && (status.current_floor == target_floor);

    //////////////////////////////////////////////////////////////////////
    // Trip control

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            state             <= elevator_pkg::DISPATCH_IDLE;
            served            <= '0;
            target_floor      <= '0;
            direction         <= elevator_pkg::DIR_DOWN;
            activate_elevator <= 1'b0;
        end else begin
            served <= '0;
            if (!enabled) begin
                // Abort the trip while the queue keeps the request
                state             <= elevator_pkg::DISPATCH_IDLE;
                activate_elevator <= 1'b0;
            end else begin
                case (state)
                    elevator_pkg::DISPATCH_IDLE: begin
                        // Wait out the cycle of a served strobe until its pop lands
                        if (!status.moving && head.valid && !served.valid) begin
                            if (head.floor == status.current_floor) begin
                                served.valid <= 1'b1;
                                served.floor <= head.floor;
                            end else begin
                                target_floor      <= head.floor;
                                direction         <= (head.floor > status.current_floor) ?
                                                     elevator_pkg::DIR_UP :
                                                     elevator_pkg::DIR_DOWN;
                                activate_elevator <= 1'b1;
                                state             <= elevator_pkg::DISPATCH_TRAVEL;
                            end
                        end
                    end
                    elevator_pkg::DISPATCH_TRAVEL: begin
                        if (arrived) begin
                            served.valid      <= 1'b1;
                            served.floor      <= target_floor;
                            activate_elevator <= 1'b0;
                            state             <= elevator_pkg::DISPATCH_IDLE;
                        end
                    end
                    default: begin
                        activate_elevator <= 1'b0;
                        state             <= elevator_pkg::DISPATCH_IDLE;
                    end
                endcase
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Door permission

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            door_open_allowed  <= 1'b0;
            door_close_allowed <= 1'b0;
        end else begin
            door_open_allowed  <= stopped && door_open_btn;
            door_close_allowed <= stopped && door_close_btn;
        end
    end

    // Drive request only during a trip toward the queue head
    a_activate_in_travel : assert property (
        @(posedge clock) disable iff (!reset_n)
        activate_elevator |-> state == elevator_pkg::DISPATCH_TRAVEL &&
                              head.valid && head.floor == target_floor
    );

endmodule

`default_nettype wire

// ==== src/floor_logic_top.sv ====
//////////////////////////////////////////////////////////////////////
// Floor request controller top. Button, emergency and power inputs
// must already be synchronous to clock
//////////////////////////////////////////////////////////////////////

`default_nettype none

`include "elevator_params.svh"

module floor_logic_top (
    input  wire                            clock,
    input  wire                            reset_n,
    input  wire  [`ELEV_FLOOR_COUNT-1:0]   floor_call_buttons,
    input  wire  [`ELEV_FLOOR_COUNT-1:0]   panel_buttons,
    input  wire                            door_open_btn,
    input  wire                            door_close_btn,
    input  wire                            emergency_btn,
    input  wire                            power_switch,
    input  elevator_pkg::floor_t           current_floor,
    input  wire                            elevator_moving,
    output elevator_pkg::floor_t           target_floor,
    output elevator_pkg::direction_t       direction,
    output logic                           activate_elevator,
    output logic [`ELEV_FLOOR_COUNT-1:0]   call_button_lights,
    output logic [`ELEV_FLOOR_COUNT-1:0]   panel_button_lights,
    output logic                           door_open_allowed,
    output logic                           door_close_allowed
);

    elevator_pkg::elevator_status_t status;
    elevator_pkg::floor_request_t   new_request;
    elevator_pkg::floor_request_t   queue_head;
    elevator_pkg::floor_request_t   served;

    // Car status bundle shared by the latch and the dispatcher
    assign status.power_on      = power_switch;
    assign status.emergency     = emergency_btn;
    assign status.moving        = elevator_moving;
    assign status.current_floor = current_floor;

    request_latch u_request_latch (
        .clock               (clock),
        .reset_n             (reset_n),
        .status              (status),
        .floor_call_buttons  (floor_call_buttons),
        .panel_buttons       (panel_buttons),
        .served              (served),
        .new_request         (new_request),
        .call_button_lights  (call_button_lights),
        .panel_button_lights (panel_button_lights)
    );

    // Served doubles as the pop strobe
    floor_queue u_floor_queue (
        .clock   (clock),
        .reset_n (reset_n),
        .push    (new_request),
        .pop     (served),
        .head    (queue_head)
    );

    dispatch_control u_dispatch_control (
        .clock              (clock),
        .reset_n            (reset_n),
        .status             (status),
        .head               (queue_head),
        .door_open_btn      (door_open_btn),
        .door_close_btn     (door_close_btn),
        .served             (served),
        .target_floor       (target_floor),
        .direction          (direction),
        .activate_elevator  (activate_elevator),
        .door_open_allowed  (door_open_allowed),
        .door_close_allowed (door_close_allowed)
    );

endmodule

`default_nettype wire

// ==== bench/floor_logic_tb.sv ====
//////////////////////////////////////////////////////////////////////
// Testbench for floor_logic_top. Run from the project root so that
// bench/floor_logic_stimulus.txt is found
//////////////////////////////////////////////////////////////////////

`default_nettype none

`include "elevator_params.svh"

module floor_logic_tb;

    localparam int N = `ELEV_FLOOR_COUNT;

    logic                     clock;
    logic                     reset_n;
    logic [N-1:0]             floor_call_buttons;
    logic [N-1:0]             panel_buttons;
    logic                     door_open_btn;
    logic                     door_close_btn;
    logic                     emergency_btn;
    logic                     power_switch;
    elevator_pkg::floor_t     current_floor;
    logic                     elevator_moving;
    elevator_pkg::floor_t     target_floor;
    elevator_pkg::direction_t direction;
    logic                     activate_elevator;
    logic [N-1:0]             call_button_lights;
    logic [N-1:0]             panel_button_lights;
    logic                     door_open_allowed;
    logic                     door_close_allowed;

    // Parsed command list
    byte  cmd_q [$];
    int   arg_q [$];
    int   exp_q [$];
    logic loaded;
    int   step_count;

    floor_logic_top UUT (
        .clock               (clock),
        .reset_n             (reset_n),
        .floor_call_buttons  (floor_call_buttons),
        .panel_buttons       (panel_buttons),
        .door_open_btn       (door_open_btn),
        .door_close_btn      (door_close_btn),
        .emergency_btn       (emergency_btn),
        .power_switch        (power_switch),
        .current_floor       (current_floor),
        .elevator_moving     (elevator_moving),
        .target_floor        (target_floor),
        .direction           (direction),
        .activate_elevator   (activate_elevator),
        .call_button_lights  (call_button_lights),
        .panel_button_lights (panel_button_lights),
        .door_open_allowed   (door_open_allowed),
        .door_close_allowed  (door_close_allowed)
    );

    initial begin
        clock = 1'b0;
    end

    always #5 clock = ~clock;

    //////////////////////////////////////////////////////////////////////
    // Car model that moves one floor every 4 cycles toward the target

    initial begin
        current_floor   = '0;
        elevator_moving = 1'b0;
        step_count      = 0;
        forever begin
            @(posedge clock);
            #1;
            if (!activate_elevator) begin
                elevator_moving = 1'b0;
            end else if (!elevator_moving) begin
                if (current_floor != target_floor) begin
                    elevator_moving = 1'b1;
                    step_count      = 0;
                end
            end else begin
                step_count = step_count + 1;
                if (step_count == 4) begin
                    step_count = 0;
                    if (target_floor > current_floor) begin
                        current_floor = current_floor + 4'd1;
                    end else begin
                        current_floor = current_floor - 4'd1;
                    end
                    if (current_floor == target_floor) begin
                        elevator_moving = 1'b0;
                    end
                end
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Helpers

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("[ERROR] %s: got 0x%0h, expected 0x%0h", name, actual, expected);
            $display("Some tests failed");
            $fatal(1);
        end
    endtask

    // Inputs change 1 unit after the rising edge
    task automatic wait_edge();
        @(posedge clock);
        #1;
    endtask

    // Panel lamps in the upper bits, call lamps below
    function automatic logic [31:0] lamp_state();
        return 32'({panel_button_lights, call_button_lights});
    endfunction

    task automatic load_stimulus();
        int    fd;
        int    code;
        string line;
        string cmd_str;
        int    arg;
        int    expv;
        fd = $fopen("bench/floor_logic_stimulus.txt", "r");
        if (fd == 0) begin
            $display("Cannot open bench/floor_logic_stimulus.txt");
            $display("Some tests failed");
            $fatal(1);
        end
        while (!$feof(fd)) begin
            code = $fgets(line, fd);
            if (code > 0 && line.len() > 0 && line[0] != "#") begin
                code = $sscanf(line, "%s %h %h", cmd_str, arg, expv);
                if (code == 3) begin
                    cmd_q.push_back(cmd_str[0]);
                    arg_q.push_back(arg);
                    exp_q.push_back(expv);
                end
            end
        end
        $fclose(fd);
    endtask

    task automatic run_command(input byte cmd, input int arg, input int expv);
        case (cmd)
            "P", "C": begin
                wait_edge();
                if (cmd == "P") begin
                    panel_buttons[arg] = 1'b1;
                end else begin
                    floor_call_buttons[arg] = 1'b1;
                end
                wait_edge();
                panel_buttons      = '0;
                floor_call_buttons = '0;
                @(negedge clock);
                check_value("{panel_button_lights, call_button_lights}", lamp_state(), expv);
            end
            "B": begin
                // Both held for two edges so the call press gets retried
                wait_edge();
                panel_buttons[arg[7:4]]      = 1'b1;
                floor_call_buttons[arg[3:0]] = 1'b1;
                wait_edge();
                @(negedge clock);
                check_value("panel_button_lights", 32'(panel_button_lights[arg[7:4]]), 1);
                check_value("call_button_lights", 32'(call_button_lights[arg[3:0]]), 0);
                wait_edge();
                panel_buttons      = '0;
                floor_call_buttons = '0;
                @(negedge clock);
                check_value("{panel_button_lights, call_button_lights}", lamp_state(), expv);
            end
            "T": begin
                @(negedge clock);
                while (!activate_elevator) begin
                    @(negedge clock);
                end
                check_value("target_floor", 32'(target_floor), arg);
                check_value("direction", 32'(direction), expv);
            end
            "A": begin
                @(negedge clock);
                while (activate_elevator) begin
                    @(negedge clock);
                end
                @(negedge clock);
                check_value("current_floor", 32'(current_floor), arg);
                check_value("{panel_button_lights, call_button_lights}", lamp_state(), expv);
            end
            "G": begin
                @(negedge clock);
                while (current_floor != elevator_pkg::floor_t'(arg)) begin
                    @(negedge clock);
                end
                check_value("elevator_moving", 32'(elevator_moving), expv);
            end
            "D": begin
                wait_edge();
                door_open_btn  = arg[0];
                door_close_btn = arg[1];
                wait_edge();
                door_open_btn  = 1'b0;
                door_close_btn = 1'b0;
                @(negedge clock);
                check_value("{door_close_allowed, door_open_allowed}",
                            32'({door_close_allowed, door_open_allowed}), expv);
            end
            "E", "W": begin
                wait_edge();
                if (cmd == "E") begin
                    emergency_btn = arg[0];
                end else begin
                    power_switch = arg[0];
                end
                @(negedge clock);
                @(negedge clock);
                check_value("activate_elevator", 32'(activate_elevator), expv);
            end
            default: begin
                $display("Unknown command %c in the stimulus file", cmd);
                $display("Some tests failed");
                $fatal(1);
            end
        endcase
    endtask

    //////////////////////////////////////////////////////////////////////
    // Main sequence and watchdog

    initial begin
        loaded             = 1'b0;
        reset_n            = 1'b0;
        floor_call_buttons = '0;
        panel_buttons      = '0;
        door_open_btn      = 1'b0;
        door_close_btn     = 1'b0;
        emergency_btn      = 1'b0;
        power_switch       = 1'b1;
        load_stimulus();
        loaded = 1'b1;
        repeat (5) @(posedge clock);
        #1;
        reset_n = 1'b1;
        for (int i = 0; i < cmd_q.size(); i++) begin
            run_command(cmd_q[i], arg_q[i], exp_q[i]);
        end
        $display("All tests passed");
        $finish;
    end

    initial begin
        wait (loaded === 1'b1);
        repeat (cmd_q.size() * 200 + 100) @(posedge clock);
        $display("Run timed out before the command list finished");
        $display("Some tests failed");
        $fatal(1);
    end

endmodule

`default_nettype wire

// ==== files.f ====
+incdir+src
src/elevator_pkg.sv
src/request_latch.sv
src/floor_queue.sv
src/dispatch_control.sv
src/floor_logic_top.sv
bench/floor_logic_tb.sv

// ==== Makefile ====
# Verilator build and run of the floor request controller testbench

SIM := obj_dir/Vfloor_logic_tb

.PHONY: all run clean

all: run

$(SIM): files.f $(wildcard src/*.sv src/*.svh bench/*.sv)
	verilator --binary --assert -Wno-fatal --top-module floor_logic_tb -f files.f

# The stimulus file path is relative to the project root
run: $(SIM)
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "All tests passed"

clean:
	rm -rf obj_dir

// ==== bench/floor_logic_stimulus.txt ====
# cmd arg expect (hex). P/C press panel/call floor, A arrive: expect {panel,call} lamps
# B panel/call nibbles, T target dir, G floor moving, D/E/W drive then expect output
D 1 1
P 0 000000
P 5 010000
P 5 010000
T 5 1
A 5 000000
C 2 000004
P 8 080004
T 2 0
A 2 080000
T 8 1
G 4 1
D 1 0
A 8 000000
B 37 004080
T 3 0
A 3 000080
T 7 1
G 5 1
E 1 0
P 9 000080
E 0 1
T 7 1
W 0 0
W 1 1
T 7 1
A 7 000000
D 3 3
